// ==== cache_req_pkg.sv ====
package cache_req_pkg;

    localparam int PADDR_W = 15;
    localparam int LINE_W  = 128;
    localparam int PTCID_W = 7;

    // physical line address of one bank.
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [1:0]         size_t;
    // the byte mask uses the same type, one mask bit per data bit.
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [PTCID_W-1:0] ptcid_t;

    typedef struct packed {
        logic       valid_e;
        logic       valid_o;
        paddr_t     paddr_e;
        paddr_t     paddr_o;
        size_t      size_e;
        size_t      size_o;
        ptcid_t     ptcid;
        logic       odd_is_greater;
        logic       need_p1;
        logic [2:0] onesize;
        logic       pcd;
    } rd_req_t;

    // same fields as rd_req_t, plus the line data and mask of each bank.
    typedef struct packed {
        logic       valid_e;
        logic       valid_o;
        paddr_t     paddr_e;
        paddr_t     paddr_o;
        line_t      data_e;
        line_t      data_o;
        size_t      size_e;
        size_t      size_o;
        line_t      mask_e;
        line_t      mask_o;
        ptcid_t     ptcid;
        logic       odd_is_greater;
        logic       need_p1;
        logic [2:0] onesize;
        logic       pcd;
    } wr_req_t;

endpackage

// ==== aq_pkg.sv ====
package aq_pkg;

    // entries per access queue.
    localparam int AQ_DEPTH = 4;
    localparam int AQ_PTR_W = 2;

    // bit positions in the one-hot source tag.
    localparam int SRC_RD  = 0;
    localparam int SRC_SW  = 1;
    localparam int SRC_WB  = 2;
    localparam int SRC_BUS = 3;

endpackage

// ==== aq_fifo.sv ====
module aq_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     write_i,
    input  logic     read_i,
    input  payload_t data_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    import aq_pkg::*;

    payload_t            mem [AQ_DEPTH];
    logic [AQ_PTR_W-1:0] wr_ptr;
    logic [AQ_PTR_W-1:0] rd_ptr;
    logic [AQ_PTR_W:0]   count;
    logic                do_write;
    logic                do_read;

    assign empty_o  = (count == '0);
    assign full_o   = (count == (AQ_PTR_W + 1)'(AQ_DEPTH));
    // a write to a full queue is dropped.
    assign do_write = write_i && !full_o;
    assign do_read  = read_i && !empty_o;

    // head entry is always presented.
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer must honour the full flag.
    assert property (@(posedge clk) disable iff (rst_i)
        !(write_i && full_o))
    else $error("aq_fifo: write while full");

    // the selector must not pop an empty queue.
    assert property (@(posedge clk) disable iff (rst_i)
        !(read_i && empty_o))
    else $error("aq_fifo: read while empty");

    assert property (@(posedge clk) disable iff (rst_i)
        count <= (AQ_PTR_W + 1)'(AQ_DEPTH))
    else $error("aq_fifo: count above depth");

endmodule

// ==== aq_select.sv ====
module aq_select (
    input  cache_req_pkg::rd_req_t rd_head_i,
    input  cache_req_pkg::rd_req_t sw_head_i,
    input  cache_req_pkg::wr_req_t wb_head_i,
    input  logic                   rd_empty_i,
    input  logic                   sw_empty_i,
    input  logic                   wb_empty_i,
    input  logic                   bus_isempty_i,
    input  logic                   bus_pcd_i,
    input  logic                   bus_valid_e_i,
    input  logic                   bus_valid_o_i,
    input  cache_req_pkg::paddr_t  bus_paddr_e_i,
    input  cache_req_pkg::paddr_t  bus_paddr_o_i,
    input  cache_req_pkg::line_t   bus_data_e_i,
    input  cache_req_pkg::line_t   bus_data_o_i,
    input  logic                   read_i,
    output logic                   rd_pop_o,
    output logic                   sw_pop_o,
    output logic                   wb_pop_o,
    output cache_req_pkg::wr_req_t req_o,
    output logic [3:0]             src_o
);

    import cache_req_pkg::*;
    import aq_pkg::*;

    wr_req_t bus_req;

    // read and store requests carry no data and no mask.
    function automatic wr_req_t widen(input rd_req_t req);
        wr_req_t w;
        w                = '0;
        w.valid_e        = req.valid_e;
        w.valid_o        = req.valid_o;
        w.paddr_e        = req.paddr_e;
        w.paddr_o        = req.paddr_o;
        w.size_e         = req.size_e;
        w.size_o         = req.size_o;
        w.ptcid          = req.ptcid;
        w.odd_is_greater = req.odd_is_greater;
        w.need_p1        = req.need_p1;
        w.onesize        = req.onesize;
        w.pcd            = req.pcd;
        return w;
    endfunction

    // a fill writes whole lines, so the mask is all ones.
    always_comb begin
        bus_req         = '0;
        bus_req.valid_e = bus_valid_e_i;
        bus_req.valid_o = bus_valid_o_i;
        bus_req.paddr_e = bus_paddr_e_i;
        bus_req.paddr_o = bus_paddr_o_i;
        bus_req.data_e  = bus_data_e_i;
        bus_req.data_o  = bus_data_o_i;
        bus_req.mask_e  = '1;
        bus_req.mask_o  = '1;
        bus_req.pcd     = bus_pcd_i;
    end

    // fixed priority: bus, wb, sw, then rd as the idle default.
    always_comb begin
        src_o = '0;
        if (!bus_isempty_i) begin
            src_o[SRC_BUS] = 1'b1;
            req_o          = bus_req;
        end else if (!wb_empty_i) begin
            src_o[SRC_WB] = 1'b1;
            req_o         = wb_head_i;
        end else if (!sw_empty_i) begin
            src_o[SRC_SW] = 1'b1;
            req_o         = widen(sw_head_i);
        end else begin
            src_o[SRC_RD] = 1'b1;
            req_o         = widen(rd_head_i);
        end
    end

    // the bus controller retires its own fill, so no pop for it.
    assign wb_pop_o = read_i && src_o[SRC_WB];
    assign sw_pop_o = read_i && src_o[SRC_SW];
    // nothing to pop when the idle default is showing.
    assign rd_pop_o = read_i && src_o[SRC_RD] && !rd_empty_i;

    always_comb begin
        assert final ($onehot(src_o))
        else $error("aq_select: source tag not one-hot");
        assert final ($onehot0({rd_pop_o, sw_pop_o, wb_pop_o}))
        else $error("aq_select: more than one queue popped");
    end

endmodule

// ==== cache_aq_sys.sv ====
module cache_aq_sys (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  read_i,
    input  logic                  rd_write_i,
    input  logic                  sw_write_i,
    input  logic                  wb_write_i,
    input  cache_req_pkg::paddr_t rd_paddr_e_i, rd_paddr_o_i,
    input  cache_req_pkg::paddr_t sw_paddr_e_i, sw_paddr_o_i,
    input  cache_req_pkg::paddr_t wb_paddr_e_i, wb_paddr_o_i,
    input  cache_req_pkg::paddr_t bus_paddr_e_i, bus_paddr_o_i,
    input  cache_req_pkg::line_t  wb_data_e_i, wb_data_o_i,
    input  cache_req_pkg::line_t  bus_data_e_i, bus_data_o_i,
    input  cache_req_pkg::line_t  wb_mask_e_i, wb_mask_o_i,
    input  cache_req_pkg::size_t  rd_size_e_i, rd_size_o_i,
    input  cache_req_pkg::size_t  sw_size_e_i, sw_size_o_i,
    input  cache_req_pkg::size_t  wb_size_e_i, wb_size_o_i,
    input  logic                  rd_valid_e_i, rd_valid_o_i,
    input  logic                  sw_valid_e_i, sw_valid_o_i,
    input  logic                  wb_valid_e_i, wb_valid_o_i,
    input  logic                  bus_valid_e_i, bus_valid_o_i,
    input  cache_req_pkg::ptcid_t rd_ptcid_i, sw_ptcid_i, wb_ptcid_i,
    input  logic                  rd_odd_is_greater_i, sw_odd_is_greater_i, wb_odd_is_greater_i,
    input  logic                  rd_need_p1_i, sw_need_p1_i, wb_need_p1_i,
    input  logic [2:0]            rd_onesize_i, sw_onesize_i, wb_onesize_i,
    input  logic                  rd_pcd_i, sw_pcd_i, wb_pcd_i, bus_pcd_i,
    input  logic                  bus_isempty_i,
    output cache_req_pkg::paddr_t paddr_e_o, paddr_o_o,
    output cache_req_pkg::line_t  data_e_o, data_o_o,
    output cache_req_pkg::size_t  size_e_o, size_o_o,
    output logic                  valid_e_o, valid_o_o,
    output cache_req_pkg::line_t  mask_e_o, mask_o_o,
    output cache_req_pkg::ptcid_t ptcid_o,
    output logic                  odd_is_greater_o,
    output logic                  need_p1_o,
    output logic [2:0]            onesize_o,
    output logic                  pcd_o,
    output logic                  r_o, sw_o, w_o, from_bus_o,
    output logic                  aq_isempty_o,
    output logic                  rdaq_isfull_o, swaq_isfull_o, wbaq_isfull_o
);

    import cache_req_pkg::*;
    import aq_pkg::*;

    rd_req_t    rd_in, sw_in, rd_head, sw_head;
    wr_req_t    wb_in, wb_head, sel_req;
    logic       rd_empty, sw_empty, wb_empty;
    logic       rd_pop, sw_pop, wb_pop;
    logic [3:0] src;

    assign rd_in = '{valid_e: rd_valid_e_i, valid_o: rd_valid_o_i,
                     paddr_e: rd_paddr_e_i, paddr_o: rd_paddr_o_i,
                     size_e: rd_size_e_i, size_o: rd_size_o_i, ptcid: rd_ptcid_i,
                     odd_is_greater: rd_odd_is_greater_i, need_p1: rd_need_p1_i,
                     onesize: rd_onesize_i, pcd: rd_pcd_i};

    assign sw_in = '{valid_e: sw_valid_e_i, valid_o: sw_valid_o_i,
                     paddr_e: sw_paddr_e_i, paddr_o: sw_paddr_o_i,
                     size_e: sw_size_e_i, size_o: sw_size_o_i, ptcid: sw_ptcid_i,
                     odd_is_greater: sw_odd_is_greater_i, need_p1: sw_need_p1_i,
                     onesize: sw_onesize_i, pcd: sw_pcd_i};

    assign wb_in = '{valid_e: wb_valid_e_i, valid_o: wb_valid_o_i,
                     paddr_e: wb_paddr_e_i, paddr_o: wb_paddr_o_i,
                     data_e: wb_data_e_i, data_o: wb_data_o_i,
                     size_e: wb_size_e_i, size_o: wb_size_o_i,
                     mask_e: wb_mask_e_i, mask_o: wb_mask_o_i, ptcid: wb_ptcid_i,
                     odd_is_greater: wb_odd_is_greater_i, need_p1: wb_need_p1_i,
                     onesize: wb_onesize_i, pcd: wb_pcd_i};

    aq_fifo #(.payload_t(rd_req_t)) rd_aq (
        .clk(clk), .rst_i(rst_i), .write_i(rd_write_i), .read_i(rd_pop),
        .data_i(rd_in), .data_o(rd_head), .empty_o(rd_empty), .full_o(rdaq_isfull_o)
    );

    aq_fifo #(.payload_t(rd_req_t)) sw_aq (
        .clk(clk), .rst_i(rst_i), .write_i(sw_write_i), .read_i(sw_pop),
        .data_i(sw_in), .data_o(sw_head), .empty_o(sw_empty), .full_o(swaq_isfull_o)
    );

    aq_fifo #(.payload_t(wr_req_t)) wb_aq (
        .clk(clk), .rst_i(rst_i), .write_i(wb_write_i), .read_i(wb_pop),
        .data_i(wb_in), .data_o(wb_head), .empty_o(wb_empty), .full_o(wbaq_isfull_o)
    );

    aq_select sel (
        .rd_head_i(rd_head), .sw_head_i(sw_head), .wb_head_i(wb_head),
        .rd_empty_i(rd_empty), .sw_empty_i(sw_empty), .wb_empty_i(wb_empty),
        .bus_isempty_i(bus_isempty_i), .bus_pcd_i(bus_pcd_i),
        .bus_valid_e_i(bus_valid_e_i), .bus_valid_o_i(bus_valid_o_i),
        .bus_paddr_e_i(bus_paddr_e_i), .bus_paddr_o_i(bus_paddr_o_i),
        .bus_data_e_i(bus_data_e_i), .bus_data_o_i(bus_data_o_i),
        .read_i(read_i),
        .rd_pop_o(rd_pop), .sw_pop_o(sw_pop), .wb_pop_o(wb_pop),
        .req_o(sel_req), .src_o(src)
    );

    assign valid_e_o        = sel_req.valid_e;
    assign valid_o_o        = sel_req.valid_o;
    assign paddr_e_o        = sel_req.paddr_e;
    assign paddr_o_o        = sel_req.paddr_o;
    assign data_e_o         = sel_req.data_e;
    assign data_o_o         = sel_req.data_o;
    assign size_e_o         = sel_req.size_e;
    assign size_o_o         = sel_req.size_o;
    assign mask_e_o         = sel_req.mask_e;
    assign mask_o_o         = sel_req.mask_o;
    assign ptcid_o          = sel_req.ptcid;
    assign odd_is_greater_o = sel_req.odd_is_greater;
    assign need_p1_o        = sel_req.need_p1;
    assign onesize_o        = sel_req.onesize;
    assign pcd_o            = sel_req.pcd;

    assign r_o        = src[SRC_RD];
    assign sw_o       = src[SRC_SW];
    assign w_o        = src[SRC_WB];
    assign from_bus_o = src[SRC_BUS];

    // idle only when no queue and no bus fill holds a request.
    assign aq_isempty_o = bus_isempty_i && wb_empty && sw_empty && rd_empty;

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset drops on a rising edge, like any other driven input.
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== tb_cache_aq_sys.sv ====
module tb_cache_aq_sys;

    import cache_req_pkg::*;
    import aq_pkg::*;

    localparam int          ROWS          = 35;
    localparam int          RESET_TIMEOUT = 32;
    localparam logic [31:0] LFSR_SEED     = 32'h11e3_55e0;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

    // each row is rd_write, sw_write, wb_write, read, bus_isempty.
    localparam logic [4:0] ROW_TABLE [ROWS] = '{
        5'b10001, 5'b10001, 5'b10001, 5'b10001, 5'b00011,
        5'b00001, 5'b00001, 5'b00011, 5'b00011, 5'b00011,
        // fill the sw queue, then read and write it together.
        5'b01001, 5'b01001, 5'b01001, 5'b01001, 5'b00011,
        5'b01011, 5'b01001, 5'b10101, 5'b10101,
        // bus fill wins over every queue, then the queues drain by priority.
        5'b00000, 5'b00010, 5'b00011, 5'b00011, 5'b00011,
        5'b00011, 5'b00011, 5'b00011, 5'b00011, 5'b00011,
        5'b00000, 5'b01111, 5'b00100, 5'b00101, 5'b00101,
        5'b00011
    };

    logic       clk;
    logic       rst;
    logic       rd_write;
    logic       sw_write;
    logic       wb_write;
    logic       read;
    logic       bus_isempty;
    rd_req_t    rd_drv;
    rd_req_t    sw_drv;
    wr_req_t    wb_drv;
    wr_req_t    bus_drv;
    wire        wr_req_t got_req;
    wire  [3:0] got_src;
    logic       aq_isempty;
    logic       rd_full;
    logic       sw_full;
    logic       wb_full;
    logic [31:0] lfsr;

    rd_req_t rd_q [$];
    rd_req_t sw_q [$];
    wr_req_t wb_q [$];

    tb_clock_gen clock_gen (.clk_o(clk), .rst_o(rst));

    cache_aq_sys dut_i (
        .clk(clk), .rst_i(rst), .read_i(read),
        .rd_write_i(rd_write), .sw_write_i(sw_write), .wb_write_i(wb_write),
        .rd_paddr_e_i(rd_drv.paddr_e), .rd_paddr_o_i(rd_drv.paddr_o),
        .sw_paddr_e_i(sw_drv.paddr_e), .sw_paddr_o_i(sw_drv.paddr_o),
        .wb_paddr_e_i(wb_drv.paddr_e), .wb_paddr_o_i(wb_drv.paddr_o),
        .bus_paddr_e_i(bus_drv.paddr_e), .bus_paddr_o_i(bus_drv.paddr_o),
        .wb_data_e_i(wb_drv.data_e), .wb_data_o_i(wb_drv.data_o),
        .bus_data_e_i(bus_drv.data_e), .bus_data_o_i(bus_drv.data_o),
        .wb_mask_e_i(wb_drv.mask_e), .wb_mask_o_i(wb_drv.mask_o),
        .rd_size_e_i(rd_drv.size_e), .rd_size_o_i(rd_drv.size_o),
        .sw_size_e_i(sw_drv.size_e), .sw_size_o_i(sw_drv.size_o),
        .wb_size_e_i(wb_drv.size_e), .wb_size_o_i(wb_drv.size_o),
        .rd_valid_e_i(rd_drv.valid_e), .rd_valid_o_i(rd_drv.valid_o),
        .sw_valid_e_i(sw_drv.valid_e), .sw_valid_o_i(sw_drv.valid_o),
        .wb_valid_e_i(wb_drv.valid_e), .wb_valid_o_i(wb_drv.valid_o),
        .bus_valid_e_i(bus_drv.valid_e), .bus_valid_o_i(bus_drv.valid_o),
        .rd_ptcid_i(rd_drv.ptcid), .sw_ptcid_i(sw_drv.ptcid), .wb_ptcid_i(wb_drv.ptcid),
        .rd_odd_is_greater_i(rd_drv.odd_is_greater),
        .sw_odd_is_greater_i(sw_drv.odd_is_greater),
        .wb_odd_is_greater_i(wb_drv.odd_is_greater),
        .rd_need_p1_i(rd_drv.need_p1), .sw_need_p1_i(sw_drv.need_p1),
        .wb_need_p1_i(wb_drv.need_p1),
        .rd_onesize_i(rd_drv.onesize), .sw_onesize_i(sw_drv.onesize),
        .wb_onesize_i(wb_drv.onesize),
        .rd_pcd_i(rd_drv.pcd), .sw_pcd_i(sw_drv.pcd), .wb_pcd_i(wb_drv.pcd),
        .bus_pcd_i(bus_drv.pcd), .bus_isempty_i(bus_isempty),
        .paddr_e_o(got_req.paddr_e), .paddr_o_o(got_req.paddr_o),
        .data_e_o(got_req.data_e), .data_o_o(got_req.data_o),
        .size_e_o(got_req.size_e), .size_o_o(got_req.size_o),
        .valid_e_o(got_req.valid_e), .valid_o_o(got_req.valid_o),
        .mask_e_o(got_req.mask_e), .mask_o_o(got_req.mask_o),
        .ptcid_o(got_req.ptcid), .odd_is_greater_o(got_req.odd_is_greater),
        .need_p1_o(got_req.need_p1), .onesize_o(got_req.onesize), .pcd_o(got_req.pcd),
        .r_o(got_src[SRC_RD]), .sw_o(got_src[SRC_SW]), .w_o(got_src[SRC_WB]),
        .from_bus_o(got_src[SRC_BUS]),
        .aq_isempty_o(aq_isempty), .rdaq_isfull_o(rd_full),
        .swaq_isfull_o(sw_full), .wbaq_isfull_o(wb_full)
    );

    // galois lfsr, one step per bit taken.
    function automatic line_t take_bits(input int n);
        line_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic rd_req_t random_rd_req();
        rd_req_t r;
        r.valid_e        = 1'(take_bits(1));
        r.valid_o        = 1'(take_bits(1));
        r.paddr_e        = PADDR_W'(take_bits(PADDR_W));
        r.paddr_o        = PADDR_W'(take_bits(PADDR_W));
        r.size_e         = 2'(take_bits(2));
        r.size_o         = 2'(take_bits(2));
        r.ptcid          = PTCID_W'(take_bits(PTCID_W));
        r.odd_is_greater = 1'(take_bits(1));
        r.need_p1        = 1'(take_bits(1));
        r.onesize        = 3'(take_bits(3));
        r.pcd            = 1'(take_bits(1));
        return r;
    endfunction

    function automatic wr_req_t random_wr_req();
        rd_req_t r;
        wr_req_t w;
        r = random_rd_req();
        w = expect_from_rd(r);
        w.data_e = take_bits(LINE_W);
        w.data_o = take_bits(LINE_W);
        w.mask_e = take_bits(LINE_W);
        w.mask_o = take_bits(LINE_W);
        return w;
    endfunction

    // read and store requests leave with no data and an empty mask.
    function automatic wr_req_t expect_from_rd(input rd_req_t r);
        return '{valid_e: r.valid_e, valid_o: r.valid_o,
                 paddr_e: r.paddr_e, paddr_o: r.paddr_o,
                 data_e: '0, data_o: '0, size_e: r.size_e, size_o: r.size_o,
                 mask_e: '0, mask_o: '0, ptcid: r.ptcid,
                 odd_is_greater: r.odd_is_greater, need_p1: r.need_p1,
                 onesize: r.onesize, pcd: r.pcd};
    endfunction

    // a fill covers whole lines; only addresses, valids, data and pcd come from the bus.
    function automatic wr_req_t expect_from_bus(input wr_req_t b);
        return '{valid_e: b.valid_e, valid_o: b.valid_o,
                 paddr_e: b.paddr_e, paddr_o: b.paddr_o,
                 data_e: b.data_e, data_o: b.data_o, size_e: '0, size_o: '0,
                 mask_e: '1, mask_o: '1, ptcid: '0,
                 odd_is_greater: 1'b0, need_p1: 1'b0, onesize: '0, pcd: b.pcd};
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_req(input string name, input wr_req_t got, input wr_req_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_src(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: source tag got %b expected %b",
                                        $time, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // priority is bus, wb, sw, rd; an idle rd head is stale and not compared.
    task automatic check_outputs();
        logic [3:0] exp_src;
        exp_src = '0;
        if (!bus_isempty) begin
            exp_src[SRC_BUS] = 1'b1;
            check_src(got_src, exp_src);
            check_req("bus fill payload", got_req, expect_from_bus(bus_drv));
        end else if (wb_q.size() != 0) begin
            exp_src[SRC_WB] = 1'b1;
            check_src(got_src, exp_src);
            check_req("wb payload", got_req, wb_q[0]);
        end else if (sw_q.size() != 0) begin
            exp_src[SRC_SW] = 1'b1;
            check_src(got_src, exp_src);
            check_req("sw payload", got_req, expect_from_rd(sw_q[0]));
        end else begin
            exp_src[SRC_RD] = 1'b1;
            check_src(got_src, exp_src);
            if (rd_q.size() != 0) begin
                check_req("rd payload", got_req, expect_from_rd(rd_q[0]));
            end
        end
        check_flag("aq_isempty_o", aq_isempty,
                   bus_isempty && rd_q.size() == 0 && sw_q.size() == 0 && wb_q.size() == 0);
        check_flag("rdaq_isfull_o", rd_full, rd_q.size() == AQ_DEPTH);
        check_flag("swaq_isfull_o", sw_full, sw_q.size() == AQ_DEPTH);
        check_flag("wbaq_isfull_o", wb_full, wb_q.size() == AQ_DEPTH);
    endtask

    // what the coming clock edge does to the queues.
    task automatic advance_model();
        logic rd_room;
        logic sw_room;
        logic wb_room;
        rd_room = rd_q.size() < AQ_DEPTH;
        sw_room = sw_q.size() < AQ_DEPTH;
        wb_room = wb_q.size() < AQ_DEPTH;
        if (read && bus_isempty) begin
            if (wb_q.size() != 0) begin
                wb_q.delete(0);
            end else if (sw_q.size() != 0) begin
                sw_q.delete(0);
            end else if (rd_q.size() != 0) begin
                rd_q.delete(0);
            end
        end
        if (rd_write && rd_room) rd_q.push_back(rd_drv);
        if (sw_write && sw_room) sw_q.push_back(sw_drv);
        if (wb_write && wb_room) wb_q.push_back(wb_drv);
    endtask

    initial begin
        int cycles;
        lfsr        = LFSR_SEED;
        rd_write    = 1'b0;
        sw_write    = 1'b0;
        wb_write    = 1'b0;
        read        = 1'b0;
        bus_isempty = 1'b1;
        rd_drv      = '0;
        sw_drv      = '0;
        wb_drv      = '0;
        bus_drv     = '0;
        cycles      = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                stop_with_failure("reset was never released");
            end
        end while (rst);
        @(negedge clk);
        check_outputs();
        for (int i = 0; i < ROWS; i++) begin
            @(posedge clk);
            rd_write    <= ROW_TABLE[i][4];
            sw_write    <= ROW_TABLE[i][3];
            wb_write    <= ROW_TABLE[i][2];
            read        <= ROW_TABLE[i][1];
            bus_isempty <= ROW_TABLE[i][0];
            rd_drv      <= random_rd_req();
            sw_drv      <= random_rd_req();
            wb_drv      <= random_wr_req();
            bus_drv     <= random_wr_req();
            @(negedge clk);
            check_outputs();
            advance_model();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== compile.f ====
cache_req_pkg.sv
aq_pkg.sv
aq_fifo.sv
aq_select.sv
cache_aq_sys.sv
tb_clock_gen.sv
tb_cache_aq_sys.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the result.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_cache_aq_sys \
    -f compile.f \
    -o sim_tb_cache_aq_sys
./obj_dir/sim_tb_cache_aq_sys
